/* project.f */
+incdir+rtl
rtl/enoc_pkg.sv
rtl/enoc_ppe_round_robin.sv
rtl/enoc_input_unit.sv
rtl/enoc_switch_control.sv
rtl/enoc_crossbar.sv
rtl/enoc_router.sv
testbench/tb_enoc_router.sv

/* rtl/enoc_crossbar.sv */
// Crossbar: grant-driven flit multiplexers feeding registered output
// flits and valid strobes

`timescale 1ns/100ps

`include "enoc_defs.svh"

module enoc_crossbar (
  input  logic                                     clk,
  input  logic                                     i_rst,
  input  logic                                     i_ce,
  input  enoc_pkg::port_mask_t [`ENOC_N_PORTS-1:0] i_output_grant,
  input  enoc_pkg::flit_t      [`ENOC_N_PORTS-1:0] i_head_flit,
  output enoc_pkg::port_mask_t                     o_out_valid,
  output enoc_pkg::flit_t      [`ENOC_N_PORTS-1:0] o_out_flit
);

  localparam int N = `ENOC_N_PORTS;

  // Flit picked for each output this cycle
  enoc_pkg::flit_t [N-1:0] sel_flit;
  // Per output, set when its arbiter granted some input
  enoc_pkg::port_mask_t    any_grant;

  // AND-OR multiplexer per output
  // Grants are one-hot, so at most one head flit reaches each output
  always_comb begin
    for (int q = 0; q < N; q++) begin
      sel_flit[q]  = '0;
      any_grant[q] = |i_output_grant[q];
      for (int p = 0; p < N; p++) begin
        sel_flit[q] = sel_flit[q] | ({`ENOC_FLIT_W{i_output_grant[q][p]}} & i_head_flit[p]);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------------------

  // Valid pulses one edge after the granting cycle
  // With clock enable low nothing is popped, so the strobe drops as well
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_out_valid <= '0;
    end else begin
      o_out_valid <= i_ce ? any_grant : '0;
    end
  end

  // Flits only load on a taken grant and hold otherwise
  always_ff @(posedge clk) begin
    for (int q = 0; q < N; q++) begin
      if (i_ce && any_grant[q]) begin
        o_out_flit[q] <= sel_flit[q];
      end
    end
  end

endmodule

/* rtl/enoc_defs.svh */
// Router geometry defines: port count, flit width, destination field
// width and input queue depth

`ifndef ENOC_DEFS_SVH
`define ENOC_DEFS_SVH

// ----------------------------------------------------------------------
// Router geometry
// ----------------------------------------------------------------------

// Number of router ports
// The router is square, so this is both the input and the output count
`define ENOC_N_PORTS 5

// Width of one flit in bits, destination field included
`define ENOC_FLIT_W 16

// Width of the destination field held in the top bits of each flit
// Three bits cover ports 0 to 4, and codes 5 to 7 are invalid
`define ENOC_DEST_W 3

// ----------------------------------------------------------------------
// Buffering
// ----------------------------------------------------------------------

// Number of flits each input queue holds before it reports full
`define ENOC_FIFO_DEPTH 4

`endif

/* rtl/enoc_input_unit.sv */
// Input unit: flit queue with full flag, invalid destination discard
// and route computation of a one-hot output request

`timescale 1ns/100ps

`include "enoc_defs.svh"

module enoc_input_unit (
  input  logic                 clk,
  input  logic                 i_rst,
  input  logic                 i_ce,
  input  logic                 i_valid,
  input  enoc_pkg::flit_t      i_flit,
  input  logic                 i_pop,
  output logic                 o_full,
  output enoc_pkg::port_mask_t o_request,
  output enoc_pkg::flit_t      o_head_flit
);

  localparam int N     = `ENOC_N_PORTS;
  localparam int DEPTH = `ENOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ----------------------------------------------------------------------
  // Queue storage and pointers
  // ----------------------------------------------------------------------

  // Flit storage, written at wr_ptr_q and read at rd_ptr_q
  enoc_pkg::flit_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // Number of flits held, from 0 up to DEPTH
  logic [CNT_W-1:0] count_q;

  logic                empty;
  logic                dest_ok;
  logic                wr_en;
  logic                rd_en;
  enoc_pkg::port_idx_t wr_dest;
  enoc_pkg::port_idx_t head_dest;

  assign empty  = (count_q == '0);
  assign o_full = (count_q == CNT_W'(DEPTH));

  // Destination field of the incoming flit
  // Codes at or above the port count name no port and are dropped here
  assign wr_dest = i_flit[`ENOC_FLIT_W-1 -: `ENOC_DEST_W];
  assign dest_ok = (wr_dest < enoc_pkg::port_idx_t'(N));

  // A write is taken only under clock enable and while there is room
  // Anything else on the write strobe is lost, as the sender is told
  // by the full flag
  assign wr_en = i_ce && i_valid && !o_full && dest_ok;
  // A pop only ever reaches a non-empty queue
  // Gating on empty keeps the read pointer from running past the writes
  assign rd_en = i_ce && i_pop && !empty;

  // Flit storage written at the write pointer
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= i_flit;
    end
  end

  // Pointers wrap at the last slot and the count tracks the fill level
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Route computation
  // ----------------------------------------------------------------------

  // The head flit goes straight to the crossbar
  assign o_head_flit = mem[rd_ptr_q];
  assign head_dest   = o_head_flit[`ENOC_FLIT_W-1 -: `ENOC_DEST_W];

  // Decode the head destination into a one-hot request on its output
  // No request is raised while the queue is empty
  always_comb begin
    o_request = '0;
    for (int q = 0; q < N; q++) begin
      if (!empty && (head_dest == enoc_pkg::port_idx_t'(q))) begin
        o_request[q] = 1'b1;
      end
    end
  end

endmodule

/* rtl/enoc_pkg.sv */
// Vector types shared across the router: flits, per-port masks and
// port numbers

`include "enoc_defs.svh"

package enoc_pkg;

  // ----------------------------------------------------------------------
  // Datapath types
  // ----------------------------------------------------------------------

  // One flit as it moves through the router
  // The destination output port sits in the top ENOC_DEST_W bits
  // The remaining low bits are payload and pass through untouched
  typedef logic [`ENOC_FLIT_W-1:0] flit_t;

  // ----------------------------------------------------------------------
  // Control types
  // ----------------------------------------------------------------------

  // One bit per router port, with bit p standing for port p
  // Used for requests, grants, pops, valids, fulls and output enables
  typedef logic [`ENOC_N_PORTS-1:0] port_mask_t;

  // A port number, as carried in the destination field of a flit
  // Also used for the round-robin priority pointers
  typedef logic [`ENOC_DEST_W-1:0] port_idx_t;

endpackage

/* rtl/enoc_ppe_round_robin.sv */
// Round-robin arbiter for one output port with a rotating priority
// pointer

`timescale 1ns/100ps

`include "enoc_defs.svh"

module enoc_ppe_round_robin (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_ce,
  input  enoc_pkg::port_mask_t i_request,
  output enoc_pkg::port_mask_t o_grant
);

  localparam int N = `ENOC_N_PORTS;

  // Input with the highest priority in the current cycle
  enoc_pkg::port_idx_t ptr_q;
  // Index of the input that wins this cycle, valid while a grant is made
  enoc_pkg::port_idx_t win_idx;

  // Scan the requests starting at the pointer and wrapping round
  // The first requester found wins, so the grant is one-hot or empty
  always_comb begin
    int   idx;
    logic found;
    found   = 1'b0;
    o_grant = '0;
    win_idx = ptr_q;
    for (int off = 0; off < N; off++) begin
      idx = (int'(ptr_q) + off) % N;
      if (!found && i_request[idx]) begin
        found        = 1'b1;
        o_grant[idx] = 1'b1;
        win_idx      = enoc_pkg::port_idx_t'(idx);
      end
    end
  end

  // Move the pointer to just past the winner when a grant is taken
  // The winner then has the lowest priority, which bounds each wait
  // to N-1 grants to other inputs
  always_ff @(posedge clk) begin
    if (i_rst) begin
      ptr_q <= '0;
    end else if (i_ce && (|o_grant)) begin
      if (win_idx == enoc_pkg::port_idx_t'(N - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= win_idx + 1'b1;
      end
    end
  end

endmodule

/* rtl/enoc_router.sv */
// Router top level: five input units feeding switch control and the
// crossbar

`timescale 1ns/100ps

`include "enoc_defs.svh"

module enoc_router #(
  parameter int N_PORTS = `ENOC_N_PORTS
) (
  input  logic                                     clk,
  input  logic                                     i_rst,
  input  logic                                     i_ce,
  input  enoc_pkg::port_mask_t                     i_in_valid,
  input  enoc_pkg::flit_t      [`ENOC_N_PORTS-1:0] i_in_flit,
  output enoc_pkg::port_mask_t                     o_in_full,
  input  enoc_pkg::port_mask_t                     i_out_en,
  output enoc_pkg::port_mask_t                     o_out_valid,
  output enoc_pkg::flit_t      [`ENOC_N_PORTS-1:0] o_out_flit
);

  // ----------------------------------------------------------------------
  // Internal wiring between the three stages
  // ----------------------------------------------------------------------

  // Input-major requests, one one-hot word per input
  enoc_pkg::port_mask_t [N_PORTS-1:0] output_req;
  // Head flit of each input queue
  enoc_pkg::flit_t      [N_PORTS-1:0] head_flit;
  // Output-major grants, one word per output
  enoc_pkg::port_mask_t [N_PORTS-1:0] output_grant;
  // Pop level back to each input queue
  enoc_pkg::port_mask_t               pop;

  // Stage 1: queue and route each input
  for (genvar p = 0; p < N_PORTS; p++) begin : g_input
    enoc_input_unit u_input_unit (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_ce        (i_ce),
      .i_valid     (i_in_valid[p]),
      .i_flit      (i_in_flit[p]),
      .i_pop       (pop[p]),
      .o_full      (o_in_full[p]),
      .o_request   (output_req[p]),
      .o_head_flit (head_flit[p])
    );
  end

  // Stage 2: arbitrate every output among its requesters
  enoc_switch_control u_switch_control (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_ce           (i_ce),
    .i_out_en       (i_out_en),
    .i_output_req   (output_req),
    .o_output_grant (output_grant),
    .o_pop          (pop)
  );

  // Stage 3: move granted head flits into the output registers
  enoc_crossbar u_crossbar (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_ce           (i_ce),
    .i_output_grant (output_grant),
    .i_head_flit    (head_flit),
    .o_out_valid    (o_out_valid),
    .o_out_flit     (o_out_flit)
  );

endmodule

/* rtl/enoc_switch_control.sv */
// Switch control for the crossbar: request transpose, output enable
// masking and one round-robin arbiter per output

`timescale 1ns/100ps

`include "enoc_defs.svh"

module enoc_switch_control (
  input  logic                                     clk,
  input  logic                                     i_rst,
  input  logic                                     i_ce,
  input  enoc_pkg::port_mask_t                     i_out_en,
  input  enoc_pkg::port_mask_t [`ENOC_N_PORTS-1:0] i_output_req,
  output enoc_pkg::port_mask_t [`ENOC_N_PORTS-1:0] o_output_grant,
  output enoc_pkg::port_mask_t                     o_pop
);

  localparam int N = `ENOC_N_PORTS;

  // Output-major request matrix, one word per output with one bit per
  // input that wants it
  enoc_pkg::port_mask_t [N-1:0] req_matrix;

  // ----------------------------------------------------------------------
  // Transpose and enable masking
  // ----------------------------------------------------------------------

  // Each input word names the single output it wants
  // Flip the matrix so each output sees its requesting inputs, and drop
  // the whole word when downstream has the output held
  always_comb begin
    for (int q = 0; q < N; q++) begin
      for (int p = 0; p < N; p++) begin
        req_matrix[q][p] = i_output_req[p][q] && i_out_en[q];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output arbitration
  // ----------------------------------------------------------------------

  // One independent arbiter per output
  // No input can win two outputs, since each input requests only one
  for (genvar q = 0; q < N; q++) begin : g_output_arb
    enoc_ppe_round_robin u_arb (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_ce      (i_ce),
      .i_request (req_matrix[q]),
      .o_grant   (o_output_grant[q])
    );
  end

  // An input pops when any output grants it
  always_comb begin
    o_pop = '0;
    for (int p = 0; p < N; p++) begin
      for (int q = 0; q < N; q++) begin
        o_pop[p] = o_pop[p] | o_output_grant[q][p];
      end
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the router testbench with Verilator, run it and judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  -f project.f \
  --top-module tb_enoc_router \
  -Mdir obj_dir \
  -o tb_enoc_router

./obj_dir/tb_enoc_router | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "Router simulation FAILED, see $LOG"
  exit 1
fi

echo "Router simulation PASSED"

/* testbench/tb_enoc_router.sv */
// Testbench for the five-port router: stimulus, scoreboard per source and
// destination pair, checks on every output edge and per-test reporting

`timescale 1ns/100ps

`include "enoc_defs.svh"

module tb_enoc_router;

  localparam int N       = `ENOC_N_PORTS;
  localparam int DEST_W  = `ENOC_DEST_W;
  // Payload layout: source port in three bits, then a sequence number
  localparam int SRC_LSB = `ENOC_FLIT_W - `ENOC_DEST_W - 3;
  localparam int FAIR_Q  = 2;
  // About four times the summed length of all tests
  localparam int MAX_CYCLES = 2000;

  logic                               clk;
  logic                               i_rst;
  logic                               i_ce;
  enoc_pkg::port_mask_t               i_in_valid;
  enoc_pkg::flit_t      [N-1:0]       i_in_flit;
  enoc_pkg::port_mask_t               o_in_full;
  enoc_pkg::port_mask_t               i_out_en;
  enoc_pkg::port_mask_t               o_out_valid;
  enoc_pkg::flit_t      [N-1:0]       o_out_flit;

  // Expected flits, one queue per source and destination pair
  enoc_pkg::flit_t sb [N*N][$];
  int seq [N];
  int deliv_cnt [N];
  int last_src [4];
  int pending = 0;
  int deliv_total = 0;
  int errors = 0;
  int test_no = 0;
  int errors_at_start = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int cycle_cnt = 0;
  int win_n = 0;
  int seed;
  logic fair_on = 1'b0;
  logic ce_prev;
  enoc_pkg::port_mask_t en_prev;
  enoc_pkg::port_mask_t hold_mask;

  enoc_router u_dut (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_ce        (i_ce),
    .i_in_valid  (i_in_valid),
    .i_in_flit   (i_in_flit),
    .o_in_full   (o_in_full),
    .i_out_en    (i_out_en),
    .o_out_valid (o_out_valid),
    .o_out_flit  (o_out_flit)
  );

  always #20 clk = ~clk;

  // Runaway guard on the whole run
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------------------

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED at %0t: %s expected 'h%0h actual 'h%0h", $time, sig, exp, act);
    errors++;
  endtask

  // Match one delivered flit against the head of its pair queue
  task automatic check_flit(input int q, input enoc_pkg::flit_t f);
    int src;
    int dst;
    enoc_pkg::flit_t exp;
    src = int'(f[SRC_LSB +: 3]);
    dst = int'(f[`ENOC_FLIT_W-1 -: DEST_W]);
    assert (dst == q) else report_mismatch($sformatf("o_out_flit[%0d] destination", q),
                                           32'(q), 32'(dst));
    if (src >= N || sb[src*N+q].size() == 0) begin
      $display("Unexpected flit 'h%h on output %0d at %0t with nothing pending for it",
               f, q, $time);
      errors++;
    end else begin
      exp = sb[src*N+q].pop_front();
      pending--;
      assert (f == exp) else report_mismatch($sformatf("o_out_flit[%0d]", q),
                                             32'(exp), 32'(f));
      // Any five deliveries in a row on the contended output differ in source
      if (fair_on && q == FAIR_Q) begin
        for (int i = 0; i < 4; i++) begin
          if (i < win_n) begin
            assert (last_src[i] != src) else begin
              $display("Fairness broken at %0t: source %0d won output %0d twice in five",
                       $time, src, q);
              errors++;
            end
          end
        end
        for (int i = 3; i > 0; i--) begin
          last_src[i] = last_src[i-1];
        end
        last_src[0] = src;
        win_n++;
      end
    end
    deliv_cnt[q]++;
    deliv_total++;
  endtask

  // Output monitor, sampling registered outputs on the clock edge
  always @(posedge clk) begin
    ce_prev <= i_ce;
    en_prev <= i_out_en;
    if (!i_rst) begin
      // A held output or a stopped clock enable in the last cycle allows no valid
      hold_mask = en_prev & {N{ce_prev}};
      assert ((o_out_valid & ~hold_mask) == '0)
        else report_mismatch("o_out_valid", 32'(o_out_valid & hold_mask), 32'(o_out_valid));
      for (int q = 0; q < N; q++) begin
        if (o_out_valid[q]) begin
          check_flit(q, o_out_flit[q]);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------

  // Advance one cycle, write strobes last one cycle only
  task automatic tick();
    @(posedge clk);
    #2;
    i_in_valid = '0;
  endtask

  // Drive one flit, and expect it only if the router will take it
  task automatic put(input int p, input int d);
    enoc_pkg::flit_t f;
    f = {DEST_W'(d), 3'(p), SRC_LSB'(seq[p])};
    seq[p]++;
    i_in_valid[p] = 1'b1;
    i_in_flit[p]  = f;
    if (i_ce && !o_in_full[p] && d < N) begin
      sb[p*N+d].push_back(f);
      pending++;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending > 0 && n < 200) begin
      tick();
      n++;
    end
    if (pending > 0) begin
      $display("Drain gave up with %0d flits never delivered", pending);
      errors++;
    end
  endtask

  task automatic start_test();
    test_no++;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      pass_cnt++;
      $display("Test %0d %s: passed", test_no, name);
    end else begin
      fail_cnt++;
      $display("Test %0d %s: failed with %0d errors", test_no, name, errors - errors_at_start);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int n;
    int base;
    enoc_pkg::flit_t sent;
    seed       = 32'h1927e280;
    clk        = 1'b0;
    i_rst      = 1'b1;
    i_ce       = 1'b1;
    i_in_valid = '0;
    i_in_flit  = '0;
    i_out_en   = '1;
    for (int p = 0; p < N; p++) begin
      seq[p]       = 0;
      deliv_cnt[p] = 0;
    end
    repeat (3) @(posedge clk);
    #2;
    i_rst = 1'b0;

    // One flit per destination, minimum latency of two edges after the drive
    start_test();
    assert (o_out_valid == '0) else report_mismatch("o_out_valid", 32'h0, 32'(o_out_valid));
    assert (o_in_full == '0) else report_mismatch("o_in_full", 32'h0, 32'(o_in_full));
    for (int d = 0; d < N; d++) begin
      put(N - 1 - d, d);
      sent = i_in_flit[N-1-d];
      n = 0;
      while (!o_out_valid[d] && n < 10) begin
        tick();
        n++;
      end
      assert (n == 2) else report_mismatch($sformatf("o_out_valid[%0d] latency", d),
                                           32'd2, 32'(n));
      assert (o_out_flit[d] == sent) else report_mismatch($sformatf("o_out_flit[%0d]", d),
                                                          32'(sent), 32'(o_out_flit[d]));
    end
    drain();
    end_test("reset and single delivery");

    // Random traffic from every input, order kept per pair
    start_test();
    repeat (150) begin
      for (int p = 0; p < N; p++) begin
        if (($random(seed) & 3) != 0 && !o_in_full[p]) begin
          put(p, int'($unsigned($random(seed)) % N));
        end
      end
      tick();
    end
    drain();
    end_test("order per pair");

    // Every input hammers one output
    start_test();
    win_n   = 0;
    fair_on = 1'b1;
    repeat (60) begin
      for (int p = 0; p < N; p++) begin
        if (!o_in_full[p]) begin
          put(p, FAIR_Q);
        end
      end
      tick();
    end
    fair_on = 1'b0;
    if (win_n < 40) begin
      $display("Only %0d deliveries seen on the contended output", win_n);
      errors++;
    end
    drain();
    end_test("round-robin fairness");

    // Output 1 held while output 4 keeps flowing
    start_test();
    i_out_en[1] = 1'b0;
    base = deliv_cnt[4];
    for (int i = 0; i < 3; i++) begin
      put(0, 1);
      put(2, 4);
      tick();
    end
    repeat (10) tick();
    assert (deliv_cnt[4] - base == 3)
      else report_mismatch("o_out_valid[4] count", 32'd3, 32'(deliv_cnt[4] - base));
    i_out_en[1] = 1'b1;
    drain();
    end_test("back-pressure");

    // Fill one queue, then try a write while full and some bad destinations
    start_test();
    i_out_en[0] = 1'b0;
    for (int i = 0; i < `ENOC_FIFO_DEPTH; i++) begin
      put(2, 0);
      tick();
    end
    assert (o_in_full[2]) else report_mismatch("o_in_full[2]", 32'd1, 32'(o_in_full[2]));
    put(2, 0);
    put(3, 5);
    tick();
    put(3, 7);
    tick();
    // A stored bad flit would block this one behind it
    put(3, 2);
    repeat (5) tick();
    i_out_en[0] = 1'b1;
    drain();
    repeat (10) tick();
    end_test("full flag and discard");

    // Clock enable low freezes delivery
    start_test();
    i_out_en = '0;
    for (int p = 0; p < N; p++) begin
      put(p, (p + 1) % N);
    end
    tick();
    i_ce     = 1'b0;
    i_out_en = '1;
    base     = deliv_total;
    put(1, 3);
    repeat (10) tick();
    assert (deliv_total == base)
      else report_mismatch("o_out_valid deliveries", 32'(base), 32'(deliv_total));
    i_ce = 1'b1;
    drain();
    end_test("clock enable");

    $display("Tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
